// File: hw/audio_pkg.sv
// sizes, register windows, control layout, opcodes and instruction fields of the audio engine
package audio_pkg;

    localparam int channels    = 8;
    localparam int frames      = 64;
    localparam int code_words  = 256;
    localparam int chan_w      = 3;
    localparam int frame_w     = 6;
    localparam int code_w      = 8;
    localparam int audio_w     = chan_w + frame_w;
    localparam int sample_w    = 16;
    localparam int acc_w       = 40;
    localparam int i2s_divider = 6;
    localparam int div_w       = $clog2(i2s_divider);

    // host_mode in bit 0, host frame above it
    localparam int control_w = frame_w + 1;

    typedef logic [31:0] addr_t;

    // each window is 256 bytes, picked by address bits 15..8
    localparam addr_t base_addr   = 32'h0000_6000;
    localparam addr_t addr_coef   = base_addr + 32'h0000;
    localparam addr_t addr_result = base_addr + 32'h0100;
    localparam addr_t addr_status = base_addr + 32'h0200;
    localparam addr_t addr_reset  = base_addr + 32'h0300;
    localparam addr_t addr_input  = base_addr + 32'h0400;

    typedef enum logic [3:0] {
        op_nop  = 4'h0,
        op_clr  = 4'h1,
        op_mac  = 4'h2,
        op_save = 4'h3,
        op_halt = 4'h4
    } op_e;

    typedef struct packed {
        logic [3:0]          opcode;
        logic [chan_w-1:0]   channel;
        logic [frame_w-1:0]  offset;
        logic [1:0]          rsvd;
        logic                slot;
        logic [sample_w-1:0] coef;
    } instr_t;

endpackage

// File: hw/i2s_link_if.sv
// I2S bit timing bundle with source, transmit and receive views
`timescale 1ns/1ns

interface i2s_link_if;

    logic       en;
    logic       sck;
    logic       ws;
    logic [5:0] posn;

    modport source (output en, output sck, output ws, output posn);

    modport tx (input en, input posn);

    modport rx (input en, input posn);

endinterface

// File: hw/i2s_clock.sv
// I2S bit enable, sck, ws and frame position derived from ck
`timescale 1ns/1ns

module i2s_clock (
    input  logic       ck,
    input  logic       rst_n,
    i2s_link_if.source link
);
    import audio_pkg::*;

    logic [div_w-1:0] div;
    logic [5:0]       posn;

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            div  <= '0;
            posn <= '0;
        end else if (link.en) begin
            div  <= '0;
            posn <= posn + 6'd1;
        end else begin
            div <= div + 1'b1;
        end
    end

    // one pulse at the end of each bit period
    assign link.en   = (div == div_w'(i2s_divider - 1));
    // sck high over the first half of the bit
    assign link.sck  = (div < div_w'(i2s_divider / 2));
    assign link.ws   = posn[5];
    assign link.posn = posn;

    en_single_pulse: assert property (
        @(posedge ck) disable iff (!rst_n)
        link.en |=> !link.en
    );

endmodule

// File: hw/i2s_tx.sv
// I2S transmitter shifting the left and right result words onto sd
`timescale 1ns/1ns

module i2s_tx (
    input  logic                          ck,
    input  logic                          rst_n,
    i2s_link_if.tx                        link,
    input  logic [audio_pkg::sample_w-1:0] left,
    input  logic [audio_pkg::sample_w-1:0] right,
    output logic                          sd
);
    import audio_pkg::*;

    logic [2*sample_w-1:0] shreg;
    logic [5:0]            next_posn;
    logic                  data_bit;

    // sd is set for the position that follows this en
    assign next_posn = link.posn + 6'd1;
    // left word on 1..16, right word on 33..48
    assign data_bit  = (next_posn[4:0] != 5'd0) && (next_posn[4:0] <= 5'd16);

    always_ff @(posedge ck) begin
        if (link.en) begin
            if (data_bit)
                shreg <= {shreg[2*sample_w-2:0], 1'b0};
        end else if (link.posn == 6'd0) begin
            shreg <= {left, right};
        end
    end

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n)
            sd <= 1'b0;
        else if (link.en)
            sd <= data_bit ? shreg[2*sample_w-1] : 1'b0;
    end

endmodule

// File: hw/i2s_rx.sv
// I2S receiver collecting sd into the left and right microphone words
`timescale 1ns/1ns

module i2s_rx (
    input  logic                          ck,
    input  logic                          rst_n,
    i2s_link_if.rx                        link,
    input  logic                          sd,
    output logic [audio_pkg::sample_w-1:0] left,
    output logic [audio_pkg::sample_w-1:0] right
);
    import audio_pkg::*;

    logic [sample_w-1:0] shreg;
    logic                data_bit;

    // msb at position 1 or 33
    assign data_bit = (link.posn[4:0] != 5'd0) && (link.posn[4:0] <= 5'd16);

    always_ff @(posedge ck) begin
        if (link.en && data_bit)
            shreg <= {shreg[sample_w-2:0], sd};
    end

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            left  <= '0;
            right <= '0;
        end else if (link.en) begin
            if (link.posn == 6'd17)
                left <= shreg;
            if (link.posn == 6'd49)
                right <= shreg;
        end
    end

endmodule

// File: hw/dpram.sv
// dual-port RAM with one write port and one registered read port
`timescale 1ns/1ns

module dpram #(
    parameter int bits = 16,
    parameter int size = 512
) (
    input  logic                    ck,
    input  logic                    we,
    input  logic [$clog2(size)-1:0] waddr,
    input  logic [bits-1:0]         wdata,
    input  logic [$clog2(size)-1:0] raddr,
    output logic [bits-1:0]         rdata
);

    logic [bits-1:0] mem [size];

    always_ff @(posedge ck) begin
        if (we)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];
    end

endmodule

// File: hw/iomem.sv
// bus window decoder giving the ready pulse and the read and write strobes
`timescale 1ns/1ns

module iomem #(
    parameter audio_pkg::addr_t base = audio_pkg::base_addr
) (
    input  logic             ck,
    input  logic             rst_n,
    input  logic             valid,
    input  logic [3:0]       wstrb,
    input  audio_pkg::addr_t addr,
    output logic             ready,
    output logic             we,
    output logic             re
);

    logic hit;
    logic write;

    assign hit   = valid && (addr[15:8] == base[15:8]);
    assign write = (wstrb != 4'h0);

    // ready doubles as the flag that the request was answered
    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n)
            ready <= 1'b0;
        else
            ready <= hit && !ready;
    end

    assign we = ready && write;
    // read strobe one cycle early so registered data lines up with ready
    assign re = hit && !ready && !write;

    ready_single_pulse: assert property (
        @(posedge ck) disable iff (!rst_n)
        ready |=> !ready
    );

endmodule

// File: hw/sequencer.sv
// program sequencer with fetch, audio read, multiply-accumulate and saturating save
`timescale 1ns/1ns

module sequencer (
    input  logic                           ck,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic [audio_pkg::frame_w-1:0]  frame,
    output logic [audio_pkg::code_w-1:0]   coef_addr,
    input  logic [31:0]                    coef_data,
    output logic [audio_pkg::audio_w-1:0]  audio_addr,
    input  logic [audio_pkg::sample_w-1:0] audio_data,
    output logic                           out_slot,
    output logic [audio_pkg::sample_w-1:0] out_sample,
    output logic                           out_we,
    output logic                           done,
    output logic                           error,
    output logic [31:0]                    capture
);
    import audio_pkg::*;

    logic                         run;
    logic [code_w-1:0]            pc;
    logic                         a_valid;
    logic                         a_last;
    instr_t                       a_instr;
    logic                         e_valid;
    logic                         e_last;
    instr_t                       e_instr;
    logic                         is_halt;
    logic                         is_bad;
    logic signed [2*sample_w-1:0] product;
    logic signed [acc_w-1:0]      acc;
    logic                         sv_valid;
    logic                         sv_slot;
    logic signed [acc_w-1:0]      sv_acc;

    // acc >>> 15 clipped to the signed sample range
    function automatic logic [sample_w-1:0] saturate(input logic signed [acc_w-1:0] a);
        logic signed [acc_w-16:0] s;
        s = a[acc_w-1:15];
        if (s > 32767)
            return 16'h7fff;
        if (s < -32768)
            return 16'h8000;
        return s[sample_w-1:0];
    endfunction

    assign coef_addr = pc;

    // audio read stage, sample at frame minus offset
    assign a_instr    = instr_t'(coef_data);
    assign audio_addr = {a_instr.channel, frame - a_instr.offset};

    assign product = $signed(e_instr.coef) * $signed(audio_data);

    always_comb begin
        is_halt = 1'b0;
        is_bad  = 1'b0;
        case (op_e'(e_instr.opcode))
            op_nop, op_clr, op_mac, op_save: is_bad = e_last;
            op_halt:                         is_halt = 1'b1;
            default:                         is_bad = 1'b1;
        endcase
    end

    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            run      <= 1'b0;
            pc       <= '0;
            a_valid  <= 1'b0;
            a_last   <= 1'b0;
            e_valid  <= 1'b0;
            e_last   <= 1'b0;
            acc      <= '0;
            done     <= 1'b0;
            error    <= 1'b0;
            sv_valid <= 1'b0;
            out_we   <= 1'b0;
            capture  <= '0;
        end else if (start) begin
            run      <= 1'b1;
            pc       <= '0;
            a_valid  <= 1'b0;
            e_valid  <= 1'b0;
            acc      <= '0;
            done     <= 1'b0;
            error    <= 1'b0;
            sv_valid <= 1'b0;
            out_we   <= 1'b0;
        end else begin
            a_valid  <= run;
            a_last   <= (pc == '1);
            e_valid  <= a_valid;
            e_last   <= a_last;
            sv_valid <= e_valid && (e_instr.opcode == op_save);
            out_we   <= sv_valid;
            if (sv_valid)
                capture <= sv_acc[31:0];
            if (run) begin
                pc <= pc + 1'b1;
                // word 255 is the last one fetched
                if (pc == '1)
                    run <= 1'b0;
            end
            if (e_valid) begin
                if (e_instr.opcode == op_clr)
                    acc <= '0;
                if (e_instr.opcode == op_mac)
                    acc <= acc + product;
                if (is_halt)
                    done <= 1'b1;
                if (is_bad)
                    error <= 1'b1;
                // drop whatever is still in flight
                if (is_halt || is_bad) begin
                    run     <= 1'b0;
                    a_valid <= 1'b0;
                    e_valid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge ck) begin
        e_instr    <= a_instr;
        sv_acc     <= acc;
        sv_slot    <= e_instr.slot;
        out_slot   <= sv_slot;
        out_sample <= saturate(sv_acc);
    end

    done_error_exclusive: assert property (
        @(posedge ck) disable iff (!rst_n)
        !(done && error)
    );

endmodule

// File: hw/audio_engine.sv
// audio engine top with host registers, capture writer, RAM muxing and soft reset
`timescale 1ns/1ns

module audio_engine (
    input  logic        ck,
    input  logic        rst_n,
    input  logic        iomem_valid,
    output logic        iomem_ready,
    input  logic [3:0]  iomem_wstrb,
    input  logic [31:0] iomem_addr,
    input  logic [31:0] iomem_wdata,
    output logic [31:0] iomem_rdata,
    output logic        sck,
    output logic        ws,
    output logic        sd_out,
    input  logic        sd_in
);
    import audio_pkg::*;

    i2s_link_if link ();

    logic [control_w-1:0] control;
    logic                 host_mode;
    logic [frame_w-1:0]   frame;
    logic [frame_w-1:0]   frame_counter;
    logic [31:0]          rdata;
    logic coef_ready, result_ready, status_ready, reset_ready, input_ready;
    logic coef_we, result_re, status_we, status_re, reset_we, input_we;

    logic                writing;
    logic [chan_w-1:0]   chan;
    logic                cap_restart;
    logic [sample_w-1:0] rx_left, rx_right, cap_data;
    logic [sample_w-1:0] left, right;

    logic [code_w-1:0]   coef_raddr;
    logic [31:0]         coef_rdata;
    logic                audio_we;
    logic [audio_w-1:0]  audio_waddr, audio_raddr;
    logic [sample_w-1:0] audio_wdata, audio_rdata;

    logic [1:0]          stretch;
    logic                start;
    logic                out_slot;
    logic [sample_w-1:0] out_sample;
    logic                out_we;
    logic                done, error;
    logic [31:0]         capture;

    assign host_mode = control[0];
    assign frame     = host_mode ? control[control_w-1:1] : frame_counter;
    assign sck       = link.sck;
    assign ws        = link.ws;

    i2s_clock i_clock (.ck(ck), .rst_n(rst_n), .link(link));

    i2s_tx i_tx (
        .ck(ck), .rst_n(rst_n), .link(link),
        .left(left), .right(right), .sd(sd_out)
    );

    i2s_rx i_rx (
        .ck(ck), .rst_n(rst_n), .link(link),
        .sd(sd_in), .left(rx_left), .right(rx_right)
    );

    // capture writer, one burst of eight channel writes per I2S frame
    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            frame_counter <= '0;
            writing       <= 1'b0;
            chan          <= '0;
            cap_restart   <= 1'b0;
        end else if (host_mode) begin
            writing     <= 1'b0;
            cap_restart <= 1'b0;
        end else begin
            cap_restart <= writing && (chan == chan_w'(channels - 1));
            if (link.en && (link.posn == 6'd0)) begin
                frame_counter <= frame_counter + 1'b1;
                writing       <= 1'b1;
                chan          <= '0;
            end else if (writing) begin
                chan <= chan + 1'b1;
                if (chan == chan_w'(channels - 1))
                    writing <= 1'b0;
            end
        end
    end

    // only lane 0 is fitted
    always_comb begin
        case (chan)
            0:       cap_data = rx_left;
            1:       cap_data = rx_right;
            default: cap_data = 16'h7fff;
        endcase
    end

    assign audio_we    = host_mode ? input_we : writing;
    assign audio_waddr = host_mode ? iomem_addr[audio_w+1:2] : {chan, frame_counter};
    assign audio_wdata = host_mode ? iomem_wdata[sample_w-1:0] : cap_data;

    // two-cycle start after reset, soft reset or end of capture
    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n)
            stretch <= 2'd0;
        else if (reset_we || cap_restart)
            stretch <= 2'd0;
        else if (stretch != 2'd2)
            stretch <= stretch + 2'd1;
    end

    assign start = (stretch != 2'd2);

    dpram #(.bits(32), .size(code_words)) i_coef_ram (
        .ck(ck), .we(coef_we), .waddr(iomem_addr[code_w+1:2]), .wdata(iomem_wdata),
        .raddr(coef_raddr), .rdata(coef_rdata)
    );

    dpram #(.bits(sample_w), .size(channels * frames)) i_audio_ram (
        .ck(ck), .we(audio_we), .waddr(audio_waddr), .wdata(audio_wdata),
        .raddr(audio_raddr), .rdata(audio_rdata)
    );

    sequencer i_seq (
        .ck(ck), .rst_n(rst_n), .start(start), .frame(frame),
        .coef_addr(coef_raddr), .coef_data(coef_rdata),
        .audio_addr(audio_raddr), .audio_data(audio_rdata),
        .out_slot(out_slot), .out_sample(out_sample), .out_we(out_we),
        .done(done), .error(error), .capture(capture)
    );

    // host registers and read data, zero outside the ready cycle
    always_ff @(posedge ck or negedge rst_n) begin
        if (!rst_n) begin
            control <= '0;
            left    <= '0;
            right   <= '0;
            rdata   <= '0;
        end else begin
            if (status_we)
                control <= iomem_wdata[control_w-1:0];
            if (out_we && !out_slot)
                left <= out_sample;
            if (out_we && out_slot)
                right <= out_sample;
            if (result_re)
                rdata <= {16'h0, iomem_addr[2] ? right : left};
            else if (status_re)
                rdata <= iomem_addr[2] ? capture : {30'h0, error, done};
            else
                rdata <= '0;
        end
    end

    iomem #(.base(addr_coef)) i_coef_io (
        .ck(ck), .rst_n(rst_n), .valid(iomem_valid), .wstrb(iomem_wstrb),
        .addr(iomem_addr), .ready(coef_ready), .we(coef_we), .re()
    );

    iomem #(.base(addr_result)) i_result_io (
        .ck(ck), .rst_n(rst_n), .valid(iomem_valid), .wstrb(iomem_wstrb),
        .addr(iomem_addr), .ready(result_ready), .we(), .re(result_re)
    );

    iomem #(.base(addr_status)) i_status_io (
        .ck(ck), .rst_n(rst_n), .valid(iomem_valid), .wstrb(iomem_wstrb),
        .addr(iomem_addr), .ready(status_ready), .we(status_we), .re(status_re)
    );

    iomem #(.base(addr_reset)) i_reset_io (
        .ck(ck), .rst_n(rst_n), .valid(iomem_valid), .wstrb(iomem_wstrb),
        .addr(iomem_addr), .ready(reset_ready), .we(reset_we), .re()
    );

    iomem #(.base(addr_input)) i_input_io (
        .ck(ck), .rst_n(rst_n), .valid(iomem_valid), .wstrb(iomem_wstrb),
        .addr(iomem_addr), .ready(input_ready), .we(input_we), .re()
    );

    assign iomem_rdata = rdata;
    assign iomem_ready = coef_ready | result_ready | status_ready | reset_ready | input_ready;

endmodule

// File: bench/audio_engine_tb.sv
// testbench for audio_engine with bus tasks, I2S model, reference model, assertions and watchdog
`timescale 1ns/1ns

module audio_engine_tb;
    import audio_pkg::*;

    logic        ck, rst_n, iomem_valid, iomem_ready, sck, ws, sd_out, sd_in;
    logic [3:0]  iomem_wstrb;
    logic [31:0] iomem_addr, iomem_wdata, iomem_rdata;
    logic [15:0] stim_lfsr, mic_lfsr;
    logic [31:0] mic_bits;
    logic [31:0] program_words [$];
    // I2S model state
    int          bitn;
    logic        last_ws;
    logic        ws_seen;
    logic [15:0] mic_word, sent_left, sent_right, frame_left, frame_right;
    logic [15:0] tx_word, tx_left, tx_right;
    event        frame_start, right_done;
    // value under check, compared one edge later
    string       chk_name;
    logic [39:0] chk_got, chk_exp;
    logic        chk_en;

    audio_engine i_audio_engine (
        .ck(ck), .rst_n(rst_n), .iomem_valid(iomem_valid), .iomem_ready(iomem_ready),
        .iomem_wstrb(iomem_wstrb), .iomem_addr(iomem_addr), .iomem_wdata(iomem_wdata),
        .iomem_rdata(iomem_rdata), .sck(sck), .ws(ws), .sd_out(sd_out), .sd_in(sd_in)
    );

    initial begin
        ck = 1'b0;
        forever #4 ck = ~ck;
    end

    task automatic stop_with_failure;
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [39:0] got,
                                   input logic [39:0] exp);
        $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        stop_with_failure();
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1, shifting right
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hb400;
        return state >> 1;
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int count,
                             output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], state[0]};
            state = lfsr_next(state);
        end
    endtask

    function automatic logic is_mapped(input logic [31:0] addr);
        return (addr[15:8] >= 8'h60) && (addr[15:8] <= 8'h64);
    endfunction

    function automatic logic [31:0] make_instr(input logic [3:0] op, input logic [2:0] chan,
                                               input logic [5:0] offset, input logic slot,
                                               input logic [15:0] coef);
        return {op, chan, offset, 2'b00, slot, coef};
    endfunction

    function automatic logic [15:0] saturate_sample(input longint acc);
        longint v;
        v = acc >>> 15;
        if (v > 32767)
            return 16'h7fff;
        if (v < -32768)
            return 16'h8000;
        return v[15:0];
    endfunction

    // ready and rdata are looked at on the falling edge, away from the update
    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        @(posedge ck);
        iomem_valid <= 1'b1;
        iomem_wstrb <= 4'hf;
        iomem_addr  <= addr;
        iomem_wdata <= data;
        do @(negedge ck); while (!iomem_ready);
        @(posedge ck);
        iomem_valid <= 1'b0;
        iomem_wstrb <= 4'h0;
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
        @(posedge ck);
        iomem_valid <= 1'b1;
        iomem_wstrb <= 4'h0;
        iomem_addr  <= addr;
        do @(negedge ck); while (!iomem_ready);
        data = iomem_rdata;
        @(posedge ck);
        iomem_valid <= 1'b0;
    endtask

    task automatic expect_equal(input string name, input logic [39:0] got,
                                input logic [39:0] exp);
        @(posedge ck);
        chk_name = name;
        chk_got  = got;
        chk_exp  = exp;
        chk_en   = 1'b1;
        @(posedge ck);
        chk_en = 1'b0;
    endtask

    task automatic load_program;
        foreach (program_words[i])
            write_word(addr_coef + 32'(4 * i), program_words[i]);
    endtask

    // soft reset, then poll until done or error
    task automatic restart_and_wait(output logic [31:0] status);
        write_word(addr_reset, 32'h0);
        read_word(addr_status, status);
        expect_equal("status after restart", status, 40'h0);
        do read_word(addr_status, status); while (status[1:0] == 2'b00);
    endtask

    // I2S source on sd_in and sink for sd_out, both sampled mid-bit
    always @(negedge sck) begin
        if (rst_n) begin
            if (ws != last_ws) begin
                // each half frame is 32 bits long
                if (ws_seen)
                    half_frame_bits: assert (bitn == 31)
                        else report_mismatch("ws half frame bits", bitn + 1, 40'd32);
                ws_seen = 1'b1;
            end
            bitn    = (ws != last_ws) ? 0 : bitn + 1;
            last_ws = ws;
            if (bitn == 0) begin
                draw_bits(mic_lfsr, 16, mic_bits);
                mic_word = mic_bits[15:0];
                // the words latched last frame are what the capture writer stores now
                if (!ws) begin
                    frame_left  = sent_left;
                    frame_right = sent_right;
                    -> frame_start;
                end
            end
            if (bitn >= 1 && bitn <= 16) begin
                sd_in   <= mic_word[16 - bitn];
                tx_word  = {tx_word[14:0], sd_out};
            end else begin
                sd_in <= 1'b0;
            end
            if (bitn == 16 && !ws) begin
                sent_left = mic_word;
                tx_left   = tx_word;
            end
            if (bitn == 16 && ws) begin
                sent_right = mic_word;
                tx_right   = tx_word;
                -> right_done;
            end
        end
    end

    // sck high for the first half of a 6-cycle bit
    sck_shape: assert property (@(posedge ck) disable iff (!rst_n)
        $rose(sck) |-> sck[*3] ##1 !sck[*3] ##1 sck
    ) else report_mismatch("sck", $sampled(sck), !$sampled(sck));

    ws_on_bit_start: assert property (@(posedge ck) disable iff (!rst_n)
        $changed(ws) |-> $rose(sck)
    ) else report_mismatch("sck", $sampled(sck), 40'h1);

    ready_follows_request: assert property (@(posedge ck) disable iff (!rst_n)
        iomem_valid && !iomem_ready && is_mapped(iomem_addr) |=> iomem_ready
    ) else report_mismatch("iomem_ready", 40'h0, 40'h1);

    ready_once: assert property (@(posedge ck) disable iff (!rst_n)
        iomem_ready |=> !iomem_ready
    ) else report_mismatch("iomem_ready", 40'h1, 40'h0);

    ready_needs_valid: assert property (@(posedge ck) disable iff (!rst_n)
        iomem_ready |-> iomem_valid
    ) else report_mismatch("iomem_valid", 40'h0, 40'h1);

    rdata_idle_zero: assert property (@(posedge ck) disable iff (!rst_n)
        !iomem_ready |-> (iomem_rdata == 32'h0)
    ) else report_mismatch("iomem_rdata", $sampled(iomem_rdata), 40'h0);

    value_matches: assert property (@(posedge ck) chk_en |-> (chk_got == chk_exp))
        else report_mismatch(chk_name, chk_got, chk_exp);

    initial begin : watchdog
        int limit_ns;
        // 4000 bit periods plus headroom for 1000 bus accesses
        limit_ns = 4000 * i2s_divider * 8 + 1000 * 4 * 8;
        #(limit_ns);
        $display("timeout: the tests did not finish within %0d ns", limit_ns);
        stop_with_failure();
    end

    initial begin : stimulus
        logic [31:0] word;
        logic [31:0] status;
        logic [5:0]  frame;
        logic [5:0]  offset;
        logic [5:0]  idx;
        logic [15:0] coefs [3];
        logic [15:0] samples [64];
        logic [15:0] left_model;
        logic [15:0] right_model;
        longint      acc;

        rst_n       = 1'b0;
        iomem_valid = 1'b0;
        iomem_wstrb = 4'h0;
        iomem_addr  = 32'h0;
        iomem_wdata = 32'h0;
        sd_in       = 1'b0;
        chk_en      = 1'b0;
        stim_lfsr   = 16'd50927;
        mic_lfsr    = 16'd50927;
        bitn        = 0;
        last_ws     = 1'b1;
        ws_seen     = 1'b0;
        sent_left   = '0;
        sent_right  = '0;
        tx_word     = '0;
        repeat (16) @(posedge ck);
        rst_n <= 1'b1;

        // host mode with a random frame
        draw_bits(stim_lfsr, 6, word);
        frame = word[5:0];
        write_word(addr_status, {25'h0, frame, 1'b1});
        // input window covers audio words 256..319, i.e. channel 4
        for (int f = 0; f < 64; f++) begin
            draw_bits(stim_lfsr, 16, word);
            samples[f] = word[15:0];
            write_word(addr_input + 32'(4 * f), {16'h0, samples[f]});
        end
        program_words = {make_instr(op_clr, 3'd0, 6'd0, 1'b0, 16'h0)};
        acc = 0;
        for (int i = 0; i < 5; i++) begin
            draw_bits(stim_lfsr, 6, word);
            offset = word[5:0];
            draw_bits(stim_lfsr, 16, word);
            idx = frame - offset;
            program_words.push_back(make_instr(op_mac, 3'd4, offset, 1'b0, word[15:0]));
            acc += longint'($signed(word[15:0])) * longint'($signed(samples[idx]));
            if (i == 2) begin
                program_words.push_back(make_instr(op_save, 3'd0, 6'd0, 1'b0, 16'h0));
                left_model = saturate_sample(acc);
            end
        end
        program_words.push_back(make_instr(op_save, 3'd0, 6'd0, 1'b1, 16'h0));
        program_words.push_back(make_instr(op_halt, 3'd0, 6'd0, 1'b0, 16'h0));
        right_model = saturate_sample(acc);
        load_program();
        restart_and_wait(status);
        expect_equal("status after halt", status, 40'h1);
        read_word(addr_result, word);
        expect_equal("left result", word, left_model);
        read_word(addr_result + 32'h4, word);
        expect_equal("right result", word, right_model);
        read_word(addr_status + 32'h4, word);
        expect_equal("capture word", word, acc[31:0]);

        // a full frame carrying the new results
        @(frame_start);
        @(right_done);
        expect_equal("sd_out left word", tx_left, left_model);
        expect_equal("sd_out right word", tx_right, right_model);

        program_words = {make_instr(op_clr, 3'd0, 6'd0, 1'b0, 16'h0),
                         make_instr(4'hf, 3'd0, 6'd0, 1'b0, 16'h0),
                         make_instr(op_halt, 3'd0, 6'd0, 1'b0, 16'h0)};
        load_program();
        restart_and_wait(status);
        expect_equal("status after unknown opcode", status, 40'h2);

        // every word a nop, so the run reaches word 255
        program_words = {};
        for (int i = 0; i < code_words; i++)
            program_words.push_back(make_instr(op_nop, 3'd0, 6'd0, 1'b0, 16'h0));
        load_program();
        restart_and_wait(status);
        expect_equal("status without halt", status, 40'h2);

        // capture path, channels 0..2 at offset 0
        for (int i = 0; i < 3; i++) begin
            draw_bits(stim_lfsr, 16, word);
            coefs[i] = word[15:0];
        end
        program_words = {make_instr(op_clr, 3'd0, 6'd0, 1'b0, 16'h0),
                         make_instr(op_mac, 3'd0, 6'd0, 1'b0, coefs[0]),
                         make_instr(op_mac, 3'd1, 6'd0, 1'b0, coefs[1]),
                         make_instr(op_mac, 3'd2, 6'd0, 1'b0, coefs[2]),
                         make_instr(op_save, 3'd0, 6'd0, 1'b0, 16'h0),
                         make_instr(op_halt, 3'd0, 6'd0, 1'b0, 16'h0)};
        load_program();
        write_word(addr_status, 32'h0);
        for (int n = 0; n < 4; n++) begin
            @(frame_start);
            // past the capture burst and the run it starts
            repeat (8) @(negedge sck);
            do read_word(addr_status, status); while (status[1:0] == 2'b00);
            expect_equal("status after capture", status, 40'h1);
            read_word(addr_status + 32'h4, word);
            acc = longint'($signed(coefs[0])) * longint'($signed(frame_left))
                + longint'($signed(coefs[1])) * longint'($signed(frame_right))
                + longint'($signed(coefs[2])) * 32767;
            expect_equal("capture word from I2S", word, acc[31:0]);
        end

        $display("test passed");
        $finish;
    end

endmodule

// File: sources.f
hw/audio_pkg.sv
hw/i2s_link_if.sv
hw/i2s_clock.sv
hw/i2s_tx.sv
hw/i2s_rx.sv
hw/dpram.sv
hw/iomem.sv
hw/sequencer.sv
hw/audio_engine.sv
bench/audio_engine_tb.sv
